/* Bender.yml */
package:
  name: rv_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv_pkg.sv
      - hdl/reg_file.sv
      - hdl/fetch_stage.sv
      - hdl/decode_stage.sv
      - hdl/execute_stage.sv
      - hdl/retire_stage.sv
      - hdl/rv_core.sv
  - target: test
    include_dirs:
      - hdl
      - sim
    files:
      - sim/tb_rv_core.sv

/* hdl/decode_stage.sv */
/*
  instruction decode, operand selection and hazard detection
  a source written by the instruction in execute costs one bubble; the
  write-back value is forwarded in front of the register bank
  unsupported encodings decode to NOP
*/
`default_nettype none
`include "rv_consts.svh"

module decode_stage (
    input  logic             clk,
    input  logic             reset,
    input  logic             stall_i,
    input  rv_pkg::word_t    instruction_i,
    input  rv_pkg::fetch_s   fetch_i,
    input  rv_pkg::tag_t     retire_tag_i,
    input  logic             wb_we_i,
    input  rv_pkg::reg_idx_t wb_rd_i,
    input  rv_pkg::word_t    wb_data_i,
    output rv_pkg::exec_s    exec_o,
    output logic             hazard_o
);
    import rv_pkg::*;

    word_t    instr_q;      // word seen in the last held cycle
    logic     held_q;
    word_t    instr;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    bank1;
    word_t    bank2;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    imm_i;
    word_t    imm_s;
    word_t    imm_b;
    word_t    imm_u;
    word_t    imm_j;
    logic     use_rs1;
    logic     use_rs2;
    exec_s    dec;

    function automatic op_e alu_op(input logic [2:0] f3);
        case (f3)
            `RV_F3_ADD: alu_op = OP_ADD;
            `RV_F3_XOR: alu_op = OP_XOR;
            `RV_F3_OR:  alu_op = OP_OR;
            `RV_F3_AND: alu_op = OP_AND;
            default:    alu_op = OP_NOP;   // shifts and compares
        endcase
    endfunction

    // while held the memory already returns the next word, so replay the copy
    assign instr = held_q ? instr_q : instruction_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            held_q  <= 1'b1;             // no fetch has returned yet
            instr_q <= `RV_NOP_INSN;
        end else begin
            held_q  <= stall_i | hazard_o;
            instr_q <= instr;
        end
    end

    assign rs1   = instr[19:15];
    assign rs2   = instr[24:20];
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    reg_file regs_i (
        .clk     (clk),
        .reset   (reset),
        .we_i    (wb_we_i),
        .rs1_i   (rs1),
        .rs2_i   (rs2),
        .rd_i    (wb_rd_i),
        .data_i  (wb_data_i),
        .data1_o (bank1),
        .data2_o (bank2)
    );

    assign rs1_data = (wb_we_i && wb_rd_i != '0 && wb_rd_i == rs1) ? wb_data_i : bank1;
    assign rs2_data = (wb_we_i && wb_rd_i != '0 && wb_rd_i == rs2) ? wb_data_i : bank2;

    always_comb begin
        dec        = '0;
        dec.op     = OP_NOP;
        dec.pc     = fetch_i.pc;
        dec.tag    = fetch_i.tag;
        dec.rd     = instr[11:7];
        dec.first  = rs1_data;
        dec.second = rs2_data;
        use_rs2    = 1'b0;
        case (instr[6:0])
            `RV_OP_REG: begin
                use_rs2 = 1'b1;
                if (instr[31:25] == 7'b0) begin
                    dec.op = alu_op(instr[14:12]);
                end else if (instr[31:25] == `RV_F7_SUB && instr[14:12] == `RV_F3_ADD) begin
                    dec.op = OP_SUB;
                end
            end
            `RV_OP_IMM: begin
                dec.op     = alu_op(instr[14:12]);
                dec.second = imm_i;
            end
            `RV_OP_LUI: begin
                dec.op     = OP_LUI;
                dec.second = imm_u;
            end
            `RV_OP_JAL: begin
                dec.op    = OP_JAL;
                dec.third = imm_j;
            end
            `RV_OP_BRANCH: begin
                use_rs2   = 1'b1;
                dec.third = imm_b;
                if (instr[14:12] == `RV_F3_BEQ) dec.op = OP_BEQ;
                if (instr[14:12] == `RV_F3_BNE) dec.op = OP_BNE;
            end
            `RV_OP_STORE: begin
                if (instr[14:12] == `RV_F3_SW) begin
                    use_rs2    = 1'b1;
                    dec.op     = OP_SW;
                    dec.second = imm_s;
                    dec.third  = rs2_data;
                end
            end
            default: ;
        endcase
        use_rs1 = !(dec.op inside {OP_NOP, OP_LUI, OP_JAL});
        dec.we  = dec.rd != '0 &&
                  dec.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_LUI, OP_JAL};
    end

    // a stale producer in execute never writes, so it needs no bubble
    assign hazard_o = exec_o.we && exec_o.tag == retire_tag_i &&
                      ((use_rs1 && rs1 == exec_o.rd) || (use_rs2 && rs2 == exec_o.rd));

    always_ff @(posedge clk) begin
        if (reset) begin
            exec_o <= '0;
        end else if (!stall_i) begin
            exec_o <= hazard_o ? '0 : dec;   // bubble while the hazard holds
        end
    end

endmodule

`default_nettype wire

/* hdl/execute_stage.sv */
/*
  ALU, branch compare and target adder
  JAL links pc+4; SW leaves its address in result and its data
  in the jump target field
*/
`default_nettype none

module execute_stage (
    input  logic            clk,
    input  logic            reset,
    input  logic            stall_i,
    input  rv_pkg::exec_s   exec_i,
    output rv_pkg::retire_s retire_o
);
    import rv_pkg::*;

    word_t   sum;
    word_t   result;
    addr_t   target;
    logic    equal;
    logic    taken;
    retire_s res;

    assign sum    = exec_i.first + exec_i.second;   // also the store address
    assign equal  = exec_i.first == exec_i.second;
    assign target = exec_i.pc + exec_i.third;

    always_comb begin
        case (exec_i.op)
            OP_ADD,
            OP_SW:   result = sum;
            OP_SUB:  result = exec_i.first - exec_i.second;
            OP_AND:  result = exec_i.first & exec_i.second;
            OP_OR:   result = exec_i.first | exec_i.second;
            OP_XOR:  result = exec_i.first ^ exec_i.second;
            OP_LUI:  result = exec_i.second;
            OP_JAL:  result = exec_i.pc + addr_t'(4);   // link value
            default: result = '0;
        endcase
    end

    assign taken = (exec_i.op == OP_BEQ && equal) ||
                   (exec_i.op == OP_BNE && !equal) ||
                   exec_i.op == OP_JAL;

    always_comb begin
        res.op          = exec_i.op;
        res.tag         = exec_i.tag;
        res.rd          = exec_i.rd;
        res.we          = exec_i.we;
        res.result      = result;
        res.jump        = taken;
        res.jump_target = (exec_i.op == OP_SW) ? exec_i.third : target;
        res.store       = exec_i.op == OP_SW;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            retire_o <= '0;
        end else if (!stall_i) begin
            retire_o <= res;
        end
    end

endmodule

`default_nettype wire

/* hdl/fetch_stage.sv */
/*
  program counter and kill tag
  the instruction memory answers one cycle after the address, so pc and
  tag are registered once more to line up with instruction_i
  a jump wins over the stall and hazard holds
*/
`default_nettype none
`include "rv_consts.svh"

module fetch_stage (
    input  logic           clk,
    input  logic           reset,
    input  logic           stall_i,
    input  logic           hazard_i,
    input  logic           jump_i,
    input  rv_pkg::addr_t  jump_target_i,
    output rv_pkg::addr_t  instruction_address_o,
    output rv_pkg::fetch_s fetch_o
);
    import rv_pkg::*;

    addr_t pc_q;
    tag_t  tag_q;
    logic  hold;

    assign hold                  = stall_i | hazard_i;
    assign instruction_address_o = pc_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q  <= `RV_RESET_PC;
            tag_q <= '0;
        end else if (jump_i) begin
            pc_q  <= jump_target_i;
            tag_q <= tag_q + 1'b1;    // everything fetched so far is stale
        end else if (!hold) begin
            pc_q  <= pc_q + addr_t'(4);
        end
    end

    // pc and tag of the word now coming back from memory
    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_o <= '{pc: `RV_RESET_PC, tag: '0};
        end else if (!hold) begin
            fetch_o <= '{pc: pc_q, tag: tag_q};
        end
    end

    // targets come from the execute adder, a bad offset shows up here
    pc_aligned_a: assert property (@(posedge clk) disable iff (reset)
        instruction_address_o[1:0] == 2'b00);

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
/*
  32 x 32 register bank, two asynchronous reads and one synchronous write
  writes to x0 are dropped; only x0 is cleared by reset
*/
`default_nettype none
`include "rv_consts.svh"

module reg_file (
    input  logic             clk,
    input  logic             reset,
    input  logic             we_i,
    input  rv_pkg::reg_idx_t rs1_i,
    input  rv_pkg::reg_idx_t rs2_i,
    input  rv_pkg::reg_idx_t rd_i,
    input  rv_pkg::word_t    data_i,
    output rv_pkg::word_t    data1_o,
    output rv_pkg::word_t    data2_o
);
    import rv_pkg::*;

    word_t regs [`RV_NREGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            regs[0] <= '0;
        end else if (we_i && rd_i != '0) begin
            regs[rd_i] <= data_i;
        end
    end

    assign data1_o = regs[rs1_i];
    assign data2_o = regs[rs2_i];

    x0_zero_a: assert property (@(posedge clk) disable iff (reset) regs[0] == '0);

endmodule

`default_nettype wire

/* hdl/retire_stage.sv */
/*
  retire, owner of the current tag
  an instruction with another tag is dropped: no write, store or jump
  all strobes are low while stalled, so each store shows for one cycle
*/
`default_nettype none

module retire_stage (
    input  logic             clk,
    input  logic             reset,
    input  logic             stall_i,
    input  rv_pkg::retire_s  retire_i,
    input  rv_pkg::word_t    store_data_i,
    output logic             wb_we_o,
    output rv_pkg::reg_idx_t wb_rd_o,
    output rv_pkg::word_t    wb_data_o,
    output logic             jump_o,
    output rv_pkg::addr_t    jump_target_o,
    output rv_pkg::tag_t     retire_tag_o,
    output logic             mem_operation_enable_o,
    output rv_pkg::be_t      mem_write_enable_o,
    output rv_pkg::addr_t    mem_address_o,
    output rv_pkg::word_t    mem_data_o
);
    import rv_pkg::*;

    tag_t tag_q;
    logic live;     // tag matches and the pipe moves
    logic store;

    assign live          = retire_i.tag == tag_q && !stall_i;
    assign wb_we_o       = live && retire_i.we;
    assign wb_rd_o       = retire_i.rd;
    assign wb_data_o     = retire_i.result;
    assign jump_o        = live && retire_i.jump;
    assign jump_target_o = retire_i.jump_target;
    assign retire_tag_o  = tag_q;

    assign store                  = live && retire_i.store;
    assign mem_operation_enable_o = store;
    assign mem_write_enable_o     = (store && retire_i.op == OP_SW) ? '1 : '0;  // word only
    assign mem_address_o          = retire_i.result & ~addr_t'(2'b11);
    assign mem_data_o             = store_data_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            tag_q <= '0;
        end else if (jump_o) begin
            tag_q <= tag_q + 1'b1;   // kills what is behind the jump
        end
    end

    jump_or_store_a: assert property (@(posedge clk) disable iff (reset)
        !(jump_o && mem_operation_enable_o));

endmodule

`default_nettype wire

/* hdl/rv_consts.svh */
/*
  widths, reset vector and instruction encodings of the core
  only the RV32I subset kept by the core is listed here
*/
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define RV_XLEN      32
`define RV_NREGS     32
`define RV_TAG_W     3
`define RV_RESET_PC  32'h0000_0000

`define RV_OP_LUI    7'b0110111
`define RV_OP_JAL    7'b1101111
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_STORE  7'b0100011
`define RV_OP_IMM    7'b0010011
`define RV_OP_REG    7'b0110011

`define RV_F3_ADD    3'b000       // ADD, SUB and ADDI
`define RV_F3_XOR    3'b100
`define RV_F3_OR     3'b110
`define RV_F3_AND    3'b111
`define RV_F3_BEQ    3'b000
`define RV_F3_BNE    3'b001
`define RV_F3_SW     3'b010
`define RV_F7_SUB    7'b0100000

`define RV_NOP_INSN  32'h0000_0013 // addi x0, x0, 0

`endif

/* hdl/rv_core.sv */
/*
  in-order RV32I subset core: fetch, decode, execute, retire
  instruction memory must return the word one cycle after the address
  stores only, word sized; no loads, CSRs, interrupts or traps
  stall_i freezes every stage
*/
`default_nettype none

module rv_core (
    input  logic          clk,
    input  logic          reset,
    input  logic          stall_i,
    input  rv_pkg::word_t instruction_i,
    output rv_pkg::addr_t instruction_address_o,
    output logic          mem_operation_enable_o,
    output rv_pkg::be_t   mem_write_enable_o,
    output rv_pkg::addr_t mem_address_o,
    output rv_pkg::word_t mem_data_o
);
    import rv_pkg::*;

    fetch_s   fetch;
    exec_s    exec;
    retire_s  retire;
    logic     hazard;
    logic     jump;
    addr_t    jump_target;
    tag_t     retire_tag;
    logic     wb_we;
    reg_idx_t wb_rd;
    word_t    wb_data;

    fetch_stage fetch_i (
        .clk                   (clk),
        .reset                 (reset),
        .stall_i               (stall_i),
        .hazard_i              (hazard),
        .jump_i                (jump),
        .jump_target_i         (jump_target),
        .instruction_address_o (instruction_address_o),
        .fetch_o               (fetch)
    );

    decode_stage decode_i (
        .clk           (clk),
        .reset         (reset),
        .stall_i       (stall_i),
        .instruction_i (instruction_i),
        .fetch_i       (fetch),
        .retire_tag_i  (retire_tag),
        .wb_we_i       (wb_we),
        .wb_rd_i       (wb_rd),
        .wb_data_i     (wb_data),
        .exec_o        (exec),
        .hazard_o      (hazard)
    );

    execute_stage execute_i (
        .clk      (clk),
        .reset    (reset),
        .stall_i  (stall_i),
        .exec_i   (exec),
        .retire_o (retire)
    );

    retire_stage retire_i (
        .clk                    (clk),
        .reset                  (reset),
        .stall_i                (stall_i),
        .retire_i               (retire),
        .store_data_i           (retire.jump_target),   // SW data rides in the target field
        .wb_we_o                (wb_we),
        .wb_rd_o                (wb_rd),
        .wb_data_o              (wb_data),
        .jump_o                 (jump),
        .jump_target_o          (jump_target),
        .retire_tag_o           (retire_tag),
        .mem_operation_enable_o (mem_operation_enable_o),
        .mem_write_enable_o     (mem_write_enable_o),
        .mem_address_o          (mem_address_o),
        .mem_data_o             (mem_data_o)
    );

endmodule

`default_nettype wire

/* hdl/rv_pkg.sv */
/*
  shared types of the core
  widths follow the constants header; tags wrap, so only a few
  jumps may be in flight at once
*/
`default_nettype none
`include "rv_consts.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0]          word_t;
    typedef logic [`RV_XLEN-1:0]          addr_t;
    typedef logic [$clog2(`RV_NREGS)-1:0] reg_idx_t;
    typedef logic [`RV_TAG_W-1:0]         tag_t;
    typedef logic [`RV_XLEN/8-1:0]        be_t;

    typedef enum logic [3:0] {
        OP_NOP = 4'd0,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_LUI,
        OP_BEQ,
        OP_BNE,
        OP_JAL,
        OP_SW
    } op_e;

    typedef struct packed {
        addr_t pc;
        tag_t  tag;
    } fetch_s;

    typedef struct packed {
        op_e      op;
        addr_t    pc;
        tag_t     tag;
        reg_idx_t rd;
        logic     we;
        word_t    first;
        word_t    second;
        word_t    third;        // store data, or branch and jump offset
    } exec_s;

    typedef struct packed {
        op_e      op;
        tag_t     tag;
        reg_idx_t rd;
        logic     we;
        word_t    result;       // ALU value, link value or store address
        logic     jump;
        addr_t    jump_target;  // holds the store data for SW
        logic     store;
    } retire_s;

endpackage

`default_nettype wire

/* sim/tb_program.svh */
/*
  program and expected stores for the core testbench
  word i of the program sits at byte address 4*i, x1 holds the store base 0x100
  stores behind taken branches and JAL must never show up
  the last word is a JAL to itself, so the core spins once the list is done
*/
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

typedef struct packed {
    addr_t addr;
    word_t data;
} store_s;

word_t  rom[$];         // instruction memory contents
store_s expected[$];    // stores in retire order

function automatic logic [`RV_XLEN-1:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                               input int rd, input int rs1, input int rs2);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `RV_OP_REG};
endfunction

function automatic logic [`RV_XLEN-1:0] i_type(input logic [2:0] f3, input int rd,
                                               input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], `RV_OP_IMM};
endfunction

// sw rs2, off(rs1)
function automatic logic [`RV_XLEN-1:0] s_type(input int rs2, input int rs1, input int off);
    return {off[11:5], rs2[4:0], rs1[4:0], `RV_F3_SW, off[4:0], `RV_OP_STORE};
endfunction

function automatic logic [`RV_XLEN-1:0] b_type(input logic [2:0] f3, input int rs1,
                                               input int rs2, input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], `RV_OP_BRANCH};
endfunction

function automatic logic [`RV_XLEN-1:0] u_type(input int rd, input int imm);
    return {imm[19:0], rd[4:0], `RV_OP_LUI};
endfunction

function automatic logic [`RV_XLEN-1:0] j_type(input int rd, input int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], `RV_OP_JAL};
endfunction

task automatic load_tables;
    rom.push_back(i_type(`RV_F3_ADD, 1, 0, 'h100));        // 0: addi x1, x0, 0x100
    rom.push_back(i_type(`RV_F3_ADD, 2, 0, 'hf3));         // 1: addi x2, x0, 0xf3
    rom.push_back(i_type(`RV_F3_ADD, 3, 0, -16));          // 2: addi x3, x0, -16
    rom.push_back(r_type(7'b0, `RV_F3_ADD, 4, 2, 3));      // 3: add x4, x2, x3
    rom.push_back(s_type(4, 1, 0));                        // 4: uses x4 right away
    rom.push_back(r_type(`RV_F7_SUB, `RV_F3_ADD, 5, 2, 3)); // 5: sub x5, x2, x3
    rom.push_back(s_type(5, 1, 4));
    rom.push_back(r_type(7'b0, `RV_F3_AND, 6, 2, 3));      // 7: and
    rom.push_back(r_type(7'b0, `RV_F3_OR, 7, 2, 3));       // 8: or
    rom.push_back(r_type(7'b0, `RV_F3_XOR, 8, 2, 3));      // 9: xor
    rom.push_back(s_type(6, 1, 8));
    rom.push_back(s_type(7, 1, 12));
    rom.push_back(s_type(8, 1, 16));
    rom.push_back(i_type(`RV_F3_ADD, 9, 2, -1));           // 13: addi x9, x2, -1
    rom.push_back(i_type(`RV_F3_AND, 10, 3, 'h7ff));       // 14: andi
    rom.push_back(i_type(`RV_F3_OR, 11, 2, 'h400));        // 15: ori
    rom.push_back(i_type(`RV_F3_XOR, 12, 2, -1));          // 16: xori, a bitwise not
    rom.push_back(s_type(9, 1, 20));
    rom.push_back(s_type(10, 1, 24));
    rom.push_back(s_type(11, 1, 28));
    rom.push_back(s_type(12, 1, 32));
    rom.push_back(u_type(13, 'h12345));                    // 21: lui x13, 0x12345
    rom.push_back(i_type(`RV_F3_ADD, 13, 13, 'h678));      // 22: depends on the lui
    rom.push_back(s_type(13, 1, -8));                      // 23: negative offset
    rom.push_back(r_type(7'b0, `RV_F3_ADD, 0, 2, 3));      // 24: add x0, discarded
    rom.push_back(s_type(0, 1, 36));
    rom.push_back(b_type(`RV_F3_BEQ, 2, 3, 8));            // 26: not taken
    rom.push_back(s_type(2, 1, 40));
    rom.push_back(b_type(`RV_F3_BNE, 2, 3, 8));            // 28: taken to 30
    rom.push_back(s_type(3, 1, 44));                       // shadow
    rom.push_back(b_type(`RV_F3_BEQ, 4, 4, 8));            // 30: taken to 32
    rom.push_back(s_type(4, 1, 48));                       // shadow
    rom.push_back(j_type(14, 12));                         // 32: jal x14 to 35
    rom.push_back(s_type(0, 1, 52));                       // shadow
    rom.push_back(s_type(1, 1, 56));                       // shadow
    rom.push_back(s_type(14, 1, 44));                      // 35: link value
    rom.push_back(b_type(`RV_F3_BNE, 2, 2, 8));            // 36: not taken
    rom.push_back(s_type(5, 1, 48));
    rom.push_back(j_type(0, 0));                           // 38: spin

    expected.push_back({32'h0000_0100, 32'h0000_00e3});
    expected.push_back({32'h0000_0104, 32'h0000_0103});
    expected.push_back({32'h0000_0108, 32'h0000_00f0});
    expected.push_back({32'h0000_010c, 32'hffff_fff3});
    expected.push_back({32'h0000_0110, 32'hffff_ff03});
    expected.push_back({32'h0000_0114, 32'h0000_00f2});
    expected.push_back({32'h0000_0118, 32'h0000_07f0});
    expected.push_back({32'h0000_011c, 32'h0000_04f3});
    expected.push_back({32'h0000_0120, 32'hffff_ff0c});
    expected.push_back({32'h0000_00f8, 32'h1234_5678});
    expected.push_back({32'h0000_0124, 32'h0000_0000});    // x0 still zero
    expected.push_back({32'h0000_0128, 32'h0000_00f3});
    expected.push_back({32'h0000_012c, 32'h0000_0084});    // pc of jal plus 4
    expected.push_back({32'h0000_0130, 32'h0000_0103});
endtask

`endif

/* sim/tb_rv_core.sv */
/*
  testbench for the core
  instruction memory is a table that answers one cycle after the address
  stall is random; every store is compared in order with the expected list
  and no store may follow the last one
*/
`default_nettype none
`include "rv_consts.svh"

module tb_rv_core;
    import rv_pkg::*;

    localparam int CLK_PERIOD     = 20;
    localparam int RESET_CYCLES   = 5;
    localparam int CYCLES_PER_ROW = 40;
    localparam int TAIL_CYCLES    = 40;   // quiet time while the core spins

    `include "tb_program.svh"

    logic   clk         = 1'b0;
    logic   reset       = 1'b1;
    logic   stall       = 1'b0;
    word_t  instruction = `RV_NOP_INSN;
    addr_t  instruction_address;
    logic   mem_operation_enable;
    be_t    mem_write_enable;
    addr_t  mem_address;
    word_t  mem_data;
    integer seed         = 20203;
    logic   stall_enable = 1'b0;
    int     store_count  = 0;

    rv_core dut_i (
        .clk                    (clk),
        .reset                  (reset),
        .stall_i                (stall),
        .instruction_i          (instruction),
        .instruction_address_o  (instruction_address),
        .mem_operation_enable_o (mem_operation_enable),
        .mem_write_enable_o     (mem_write_enable),
        .mem_address_o          (mem_address),
        .mem_data_o             (mem_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic word_t read_rom(input addr_t addr);
        int idx;
        idx = int'(addr[31:2]);
        if (idx < rom.size()) begin
            return rom[idx];
        end
        return `RV_NOP_INSN;     // past the end of the program
    endfunction

    // synchronous memory, word of the previous cycle's address
    always @(posedge clk) begin
        instruction <= read_rom(instruction_address);
    end

    always @(posedge clk) begin
        if (stall_enable) begin
            stall <= ($random(seed) & 3) == 0;   // about one cycle in four
        end
    end

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input word_t expected_value,
                         input word_t actual_value);
        if (actual_value !== expected_value) begin
            stop_on_error($sformatf("[ERROR] %s: expected %h, actual %h",
                                    name, expected_value, actual_value));
        end
    endtask

    // a store counts only in a cycle that is not stalled
    // strobes stay low in every other cycle
    task automatic wait_for_store;
        @(negedge clk);
        while (!(mem_operation_enable && !stall)) begin
            check("write enables outside a store", '0, word_t'(mem_write_enable));
            check("store enable while stalled", '0, word_t'(mem_operation_enable));
            @(negedge clk);
        end
    endtask

    initial begin
        load_tables();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check("first fetch address", `RV_RESET_PC, instruction_address);
        check("store enable after reset", '0, word_t'(mem_operation_enable));
        check("write enables after reset", '0, word_t'(mem_write_enable));
        stall_enable = 1'b1;

        for (int i = 0; i < expected.size(); i++) begin
            wait_for_store();
            check($sformatf("store %0d address", i), expected[i].addr, mem_address);
            check($sformatf("store %0d data", i), expected[i].data, mem_data);
            check($sformatf("store %0d write enables", i), word_t'(4'hf),
                  word_t'(mem_write_enable));
            store_count++;
        end

        repeat (TAIL_CYCLES) begin
            @(negedge clk);
            if (mem_operation_enable || mem_write_enable != '0) begin
                stop_on_error("a store appeared after the last expected store");
            end
        end

        $display("Simulation completed successfully");
        $finish;
    end

    initial begin
        @(negedge reset);
        #(rom.size() * CYCLES_PER_ROW * CLK_PERIOD);
        stop_on_error($sformatf("timeout, only %0d of %0d stores seen",
                                store_count, expected.size()));
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+hdl
+incdir+sim
hdl/rv_pkg.sv
hdl/reg_file.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/retire_stage.sv
hdl/rv_core.sv
sim/tb_rv_core.sv
